/* i3c_ibi.f */
source/i3c_ibi_pkg.sv
source/bus_monitor.sv
source/bus_tx.sv
source/bus_rx.sv
source/ibi_queue.sv
source/ibi_fsm.sv
source/i3c_ibi_top.sv
testbench/i3c_ibi_props.sv
testbench/tb_i3c_ibi.sv

/* Makefile */
TOP := tb_i3c_ibi

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f i3c_ibi.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

/* testbench/tb_i3c_ibi.sv */
// Testbench for the IBI path with an I3C controller model on a wired-AND SDA line
`default_nettype none

module tb_i3c_ibi;
  import i3c_ibi_pkg::*;

  typedef enum int {ModeAck, ModeNack, ModeStop, ModeFlush} mode_e;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic scl_drv;
  logic ctl_sda;
  logic wr_en_i;
  ibi_byte_t wr_byte_i;
  logic begin_i;
  logic ibi_abort_i;
  logic [6:0] target_ibi_addr_i;
  logic target_ibi_addr_valid_i;
  logic [2:0] ibi_retry_num_i;
  logic [THdDatWidth-1:0] t_hd_dat_i;
  wire sda_o;
  wire done_o;
  wire ibi_status_we_o;
  wire queue_full_o;
  ibi_status_e ibi_status_o;
  wire sda_line;

  int errors = 0;
  int checks = 0;
  int done_cnt = 0;
  logic watch_quiet = 1'b0;
  logic [31:0] seed = 32'h1220;
  logic [2:0] m_cnt = 3'd7;
  ibi_status_e exp_status = IbiSuccess;
  logic [7:0] exp_q[$];

  // Open-drain line shared by target and controller
  assign sda_line = sda_o & ctl_sda;

  i3c_ibi_top UUT (
    .clk_i, .rst_ni, .scl_i(scl_drv), .sda_i(sda_line), .wr_en_i, .wr_byte_i, .begin_i,
    .ibi_abort_i, .target_ibi_addr_i, .target_ibi_addr_valid_i, .ibi_retry_num_i,
    .t_hd_dat_i, .sda_o, .done_o, .ibi_status_o, .ibi_status_we_o, .queue_full_o
  );

  always #2 clk_i = ~clk_i;

  function automatic logic [7:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed[23:16];
  endfunction

  task automatic report_mismatch(input string msg);
    errors++;
    $display("CHECK FAILED at time %0t: %s", $time, msg);
  endtask

  task automatic tick(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  // Outputs sampled away from the rising edge
  always @(negedge clk_i) begin
    if (done_o) done_cnt++;
    if (ibi_status_we_o) begin
      assert (ibi_status_o == exp_status) checks++;
      else report_mismatch($sformatf("status %0d, expected %0d", ibi_status_o, exp_status));
    end
    if (watch_quiet) begin
      assert (sda_o) checks++;
      else report_mismatch("target pulled SDA low while it should stay quiet");
    end
  end

  // One SCL period, sampling in the middle of the high phase
  task automatic clock_bit(input logic pull_low, output logic b);
    scl_drv = 1'b0;
    tick(1);
    ctl_sda = ~pull_low;
    tick(7);
    scl_drv = 1'b1;
    tick(4);
    b = sda_line;
    tick(4);
  endtask

  task automatic collect_byte(output logic [7:0] v);
    logic b;
    v = '0;
    for (int i = 0; i < 8; i++) begin
      clock_bit(1'b0, b);
      v = {v[6:0], b};
    end
  endtask

  task automatic issue_stop();
    scl_drv = 1'b0;
    tick(1);
    ctl_sda = 1'b0;
    tick(7);
    scl_drv = 1'b1;
    tick(4);
    ctl_sda = 1'b1;
    tick(4);
  endtask

  task automatic controller(input mode_e mode, input int nbytes);
    logic [7:0] v;
    logic [7:0] want;
    logic b;
    wait (sda_line == 1'b0);
    tick(8);
    collect_byte(v);
    assert (v == {target_ibi_addr_i, 1'b1}) checks++;
    else report_mismatch($sformatf("address byte %h", v));
    clock_bit(mode != ModeNack, b);
    if (mode == ModeNack) begin
      watch_quiet = 1'b1;
      issue_stop();
      return;
    end
    for (int i = 0; i < nbytes; i++) begin
      collect_byte(v);
      want = exp_q.pop_front();
      assert (v == want) checks++;
      else report_mismatch($sformatf("data byte %h, expected %h", v, want));
      if (mode == ModeStop) begin
        issue_stop();
        return;
      end
      clock_bit(1'b0, b);
      assert (b == (i != nbytes - 1)) checks++;
      else report_mismatch($sformatf("T bit %b after byte %0d", b, i));
    end
    issue_stop();
  endtask

  // SDA held low from the first SCL fall until the hold time has passed
  task automatic measure_hold();
    int cnt;
    cnt = 0;
    if (t_hd_dat_i == '0) return;
    wait (scl_drv == 1'b0);
    while (sda_line == 1'b0) begin
      tick(1);
      cnt++;
    end
    assert (cnt >= int'(t_hd_dat_i)) checks++;
    else report_mismatch($sformatf("SDA low for %0d cycles after SCL fall", cnt));
  endtask

  task automatic fill_queue(input int n);
    for (int i = 0; i < n; i++) begin
      wr_byte_i = '{last: (i == n - 1), data: next_rand()};
      exp_q.push_back(wr_byte_i.data);
      wr_en_i = 1'b1;
      tick(1);
    end
    wr_en_i = 1'b0;
  endtask

  // The number of writes until the queue is full shows how many bytes it held
  task automatic check_occupancy(input int held);
    for (int i = 0; i < int'(IbiQueueDepth) - held; i++) begin
      assert (!queue_full_o) checks++;
      else report_mismatch($sformatf("queue full after %0d writes", i));
      wr_byte_i = '{last: 1'b0, data: next_rand()};
      wr_en_i = 1'b1;
      tick(1);
    end
    wr_en_i = 1'b0;
    assert (queue_full_o) checks++;
    else report_mismatch($sformatf("queue not full with %0d bytes held", held));
    ibi_abort_i = 1'b1;
    tick(1);
    ibi_abort_i = 1'b0;
  endtask

  task automatic run_ibi(input mode_e mode, input int nbytes);
    int done_before;
    if (ibi_retry_num_i != RetryUnlimited && ibi_retry_num_i == m_cnt) mode = ModeFlush;
    fill_queue(nbytes);
    case (mode)
      ModeAck: exp_status = IbiSuccess;
      ModeNack: exp_status = (exp_status == IbiSuccess) ? IbiFailureNack : IbiFailureRetry;
      ModeStop: exp_status = (exp_status == IbiSuccess) ? IbiFailurePartialData : IbiFailureRetry;
      default: watch_quiet = 1'b1;
    endcase
    done_before = done_cnt;
    begin_i = 1'b1;
    tick(1);
    begin_i = 1'b0;
    if (mode != ModeFlush) begin
      fork
        controller(mode, nbytes);
        measure_hold();
      join
    end
    wait (done_cnt != done_before);
    m_cnt = (exp_status == IbiFailureNack) ? m_cnt + 3'd1 : 3'd7;
    tick(BusIdleCycles + 8);
    watch_quiet = 1'b0;
    assert (done_cnt == done_before + 1) checks++;
    else report_mismatch($sformatf("%0d done pulses", done_cnt - done_before));
    exp_q.delete();
    // A NACKed IBI sends nothing, so its bytes stay queued for the retry
    check_occupancy((mode == ModeNack) ? nbytes : 0);
  endtask

  initial begin : watchdog
    int limit;
    limit = 16 * (9 * (IbiQueueDepth + 1) + 4 * BusIdleCycles) * 16;
    repeat (limit) @(posedge clk_i);
    $display("Watchdog expired before the tests finished");
    $display("Test failed");
    $finish;
  end

  initial begin
    int done_before;
    rst_ni = 1'b0;
    scl_drv = 1'b1;
    ctl_sda = 1'b1;
    wr_en_i = 1'b0;
    wr_byte_i = '0;
    begin_i = 1'b0;
    ibi_abort_i = 1'b0;
    target_ibi_addr_i = 7'h5a;
    target_ibi_addr_valid_i = 1'b1;
    ibi_retry_num_i = RetryUnlimited;
    t_hd_dat_i = '0;
    tick(2);
    rst_ni = 1'b1;
    tick(BusIdleCycles + 4);
    run_ibi(ModeAck, 3);
    run_ibi(ModeNack, 2);
    run_ibi(ModeAck, 1);
    run_ibi(ModeStop, 3);
    run_ibi(ModeStop, 2);
    ibi_retry_num_i = 3'd2;
    repeat (3) run_ibi(ModeNack, 1);
    // Limit of zero is hit right after one NACK
    ibi_retry_num_i = 3'd0;
    run_ibi(ModeAck, 1);
    run_ibi(ModeNack, 1);
    run_ibi(ModeNack, 2);
    ibi_retry_num_i = RetryUnlimited;
    target_ibi_addr_valid_i = 1'b0;
    done_before = done_cnt;
    watch_quiet = 1'b1;
    begin_i = 1'b1;
    tick(1);
    begin_i = 1'b0;
    tick(4 * BusIdleCycles);
    watch_quiet = 1'b0;
    assert (done_cnt == done_before) checks++;
    else report_mismatch("done_o pulsed for an invalid address");
    target_ibi_addr_valid_i = 1'b1;
    // Longer than the synchronizer delay, shorter than the SCL low phase
    t_hd_dat_i = THdDatWidth'(4);
    run_ibi(ModeAck, IbiQueueDepth);
    $display("Checks passed: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/i3c_ibi_props.sv */
// Concurrent checks on the IBI sequencer handshakes, bound into every ibi_fsm instance
`default_nettype none

module ibi_fsm_props (
  input wire clk_i,
  input wire rst_ni,
  input wire done_i,
  input wire status_we_i,
  input wire q_ready_i,
  input wire tx_done_i,
  input wire tx_req_byte_i,
  input wire tx_req_bit_i,
  input wire rx_req_bit_i,
  input wire rx_done_i,
  input wire rx_nack_i,
  input wire stop_i
);

  logic nack_seen_q;

  // Set by a NACKed address, cleared once the IBI finishes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nack_seen_q <= 1'b0;
    end else if (done_i) begin
      nack_seen_q <= 1'b0;
    end else if (rx_done_i && rx_nack_i) begin
      nack_seen_q <= 1'b1;
    end
  end

  // Done is a single-cycle pulse
  done_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |=> !done_i)
    else $error("done_o stayed high for more than one cycle");

  status_we_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    status_we_i |-> (done_i || (stop_i && nack_seen_q)))
    else $error("ibi_status_we_o high outside Done and STOP after NACK");

  // Pops only at the end of a T bit or while no transfer is requested
  q_ready_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    q_ready_i |-> ((tx_req_bit_i && tx_done_i) ||
                   (!tx_req_byte_i && !tx_req_bit_i && !rx_req_bit_i)))
    else $error("q_ready_o high outside SendTbit done or Flush");

  // A flush keeps popping until the queue is empty, then finishes
  flush_drains: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (q_ready_i && !tx_req_bit_i) |=> (q_ready_i || done_i))
    else $error("flush stopped before the IBI finished");

endmodule

bind ibi_fsm ibi_fsm_props u_props (
  .clk_i(clk_i),
  .rst_ni(rst_ni),
  .done_i(done_o),
  .status_we_i(ibi_status_we_o),
  .q_ready_i(q_ready_o),
  .tx_done_i(tx_done_i),
  .tx_req_byte_i(tx_req_byte_o),
  .tx_req_bit_i(tx_req_bit_o),
  .rx_req_bit_i(rx_req_bit_o),
  .rx_done_i(rx_done_i),
  .rx_nack_i(rx_value_i[0]),
  .stop_i(bus_event_i.stop)
);

`default_nettype wire

/* source/i3c_ibi_top.sv */
// Top of the I3C target IBI path, joining queue, bus monitor, sequencer and the SDA serializers
`default_nettype none

module i3c_ibi_top (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                scl_i,
  input  logic                                sda_i,
  input  logic                                wr_en_i,
  input  i3c_ibi_pkg::ibi_byte_t              wr_byte_i,
  input  logic                                begin_i,
  input  logic                                ibi_abort_i,
  input  logic [6:0]                          target_ibi_addr_i,
  input  logic                                target_ibi_addr_valid_i,
  input  logic [2:0]                          ibi_retry_num_i,
  input  logic [i3c_ibi_pkg::THdDatWidth-1:0] t_hd_dat_i,
  output logic                                sda_o,
  output logic                                done_o,
  output i3c_ibi_pkg::ibi_status_e            ibi_status_o,
  output logic                                ibi_status_we_o,
  output logic                                queue_full_o
);
  import i3c_ibi_pkg::*;

  ibi_byte_t  q_byte;
  bus_event_t bus_event;
  logic       q_valid;
  logic       q_ready;
  logic       tx_req_byte;
  logic       tx_req_bit;
  logic [7:0] tx_value;
  logic       tx_push_pull;
  logic       tx_done;
  logic       tx_sda_low;
  logic       rx_req_bit;
  logic       rx_done;
  logic [7:0] rx_value;
  logic       sda_start_low;

  // Abort goes straight to the queue flush
  ibi_queue u_queue (
    .clk_i, .rst_ni, .wr_en_i, .wr_byte_i,
    .flush_i(ibi_abort_i), .rd_ready_i(q_ready),
    .rd_valid_o(q_valid), .rd_byte_o(q_byte), .full_o(queue_full_o)
  );

  bus_monitor u_monitor (.clk_i, .rst_ni, .scl_i, .sda_i, .bus_event_o(bus_event));

  ibi_fsm u_fsm (
    .clk_i, .rst_ni, .begin_i, .target_ibi_addr_i, .target_ibi_addr_valid_i,
    .ibi_retry_num_i, .t_hd_dat_i, .bus_event_i(bus_event),
    .q_valid_i(q_valid), .q_byte_i(q_byte), .tx_done_i(tx_done),
    .rx_done_i(rx_done), .rx_value_i(rx_value), .q_ready_o(q_ready),
    .tx_req_byte_o(tx_req_byte), .tx_req_bit_o(tx_req_bit), .tx_value_o(tx_value),
    .tx_push_pull_o(tx_push_pull), .rx_req_bit_o(rx_req_bit),
    .sda_start_low_o(sda_start_low), .done_o, .ibi_status_o, .ibi_status_we_o
  );

  bus_tx u_tx (
    .clk_i, .rst_ni, .bus_event_i(bus_event), .req_byte_i(tx_req_byte),
    .req_bit_i(tx_req_bit), .value_i(tx_value), .push_pull_i(tx_push_pull),
    .sda_low_o(tx_sda_low), .done_o(tx_done)
  );

  // The IBI only ever reads single ACK bits
  bus_rx u_rx (
    .clk_i, .rst_ni, .bus_event_i(bus_event), .sda_i, .req_byte_i(1'b0),
    .req_bit_i(rx_req_bit), .value_o(rx_value), .done_o(rx_done)
  );

  // Open drain, released means high
  assign sda_o = ~(sda_start_low | tx_sda_low);

endmodule

`default_nettype wire

/* source/ibi_fsm.sv */
// Sequences one IBI from forced START through address, ACK, data and T bits, and keeps status
`default_nettype none

module ibi_fsm (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     begin_i,
  input  logic [6:0]                               target_ibi_addr_i,
  input  logic                                     target_ibi_addr_valid_i,
  input  logic [2:0]                               ibi_retry_num_i,
  input  logic [i3c_ibi_pkg::THdDatWidth-1:0]      t_hd_dat_i,
  input  i3c_ibi_pkg::bus_event_t                  bus_event_i,
  input  logic                                     q_valid_i,
  input  i3c_ibi_pkg::ibi_byte_t                   q_byte_i,
  input  logic                                     tx_done_i,
  input  logic                                     rx_done_i,
  input  logic [7:0]                               rx_value_i,
  output logic                                     q_ready_o,
  output logic                                     tx_req_byte_o,
  output logic                                     tx_req_bit_o,
  output logic [7:0]                               tx_value_o,
  output logic                                     tx_push_pull_o,
  output logic                                     rx_req_bit_o,
  output logic                                     sda_start_low_o,
  output logic                                     done_o,
  output i3c_ibi_pkg::ibi_status_e                 ibi_status_o,
  output logic                                     ibi_status_we_o
);
  import i3c_ibi_pkg::*;

  typedef enum logic [3:0] {
    Idle             = 4'd0,
    WaitAvail        = 4'd1,
    DriveStart       = 4'd2,
    DriveAddr        = 4'd3,
    ReadAck          = 4'd4,
    WaitSclNeg       = 4'd5,
    SendData         = 4'd6,
    SendTbit         = 4'd7,
    WaitStopOrRstart = 4'd8,
    Flush            = 4'd9,
    Done             = 4'd10
  } state_e;

  state_e                 state_q;
  state_e                 state_d;
  ibi_status_e            status_q;
  ibi_status_e            fail_status;
  logic [2:0]             retry_cnt_q;
  logic [THdDatWidth-1:0] tcount_q;
  logic                   can_retry;
  logic                   nack;
  logic                   stop;

  assign stop      = bus_event_i.stop;
  assign nack      = rx_value_i[0];
  assign can_retry = (ibi_retry_num_i == RetryUnlimited) || (ibi_retry_num_i != retry_cnt_q);

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle: begin
        if (begin_i && target_ibi_addr_valid_i) begin
          state_d = can_retry ? WaitAvail : Flush;
        end
      end
      WaitAvail: begin
        if (stop) state_d = Done;
        else if (bus_event_i.bus_available) state_d = DriveStart;
      end
      DriveStart: begin
        if (stop) begin
          state_d = Done;
        end else if ((t_hd_dat_i == '0 && bus_event_i.scl_negedge) || tcount_q == '0) begin
          state_d = DriveAddr;
        end
      end
      DriveAddr: begin
        if (stop) state_d = Done;
        else if (tx_done_i) state_d = ReadAck;
      end
      ReadAck: begin
        if (stop) state_d = Done;
        else if (rx_done_i) state_d = nack ? WaitStopOrRstart : WaitSclNeg;
      end
      WaitSclNeg: if (bus_event_i.scl_negedge) state_d = SendData;
      SendData: begin
        if (stop) state_d = Flush;
        else if (tx_done_i) state_d = SendTbit;
      end
      SendTbit: begin
        if (stop) state_d = Flush;
        else if (tx_done_i) state_d = q_byte_i.last ? Done : SendData;
      end
      WaitStopOrRstart: if (stop || bus_event_i.rstart) state_d = Done;
      Flush: if (!q_valid_i) state_d = Done;
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Data hold count after the first SCL fall, all ones when idle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tcount_q <= '1;
    end else if (state_q == DriveStart && bus_event_i.scl_negedge && tcount_q == '1) begin
      tcount_q <= t_hd_dat_i - THdDatWidth'(1);
    end else if (tcount_q != '1) begin
      tcount_q <= tcount_q - THdDatWidth'(1);
    end
  end

  always_comb begin
    tx_req_byte_o  = 1'b0;
    tx_req_bit_o   = 1'b0;
    tx_value_o     = '0;
    tx_push_pull_o = 1'b0;
    rx_req_bit_o   = 1'b0;
    q_ready_o      = 1'b0;
    case (state_q)
      DriveAddr: begin
        tx_req_byte_o = 1'b1;
        tx_value_o    = {target_ibi_addr_i, 1'b1};
      end
      ReadAck: rx_req_bit_o = 1'b1;
      SendData: begin
        tx_req_byte_o  = 1'b1;
        tx_value_o     = q_byte_i.data;
        tx_push_pull_o = 1'b1;
      end
      SendTbit: begin
        tx_req_bit_o   = 1'b1;
        tx_value_o     = {7'b0, ~q_byte_i.last};
        tx_push_pull_o = 1'b1;
        q_ready_o      = tx_done_i;
      end
      Flush: q_ready_o = 1'b1;
      default: ;
    endcase
  end

  // A failure after an earlier failure is reported as retry
  always_comb begin
    fail_status = IbiFailureRetry;
    if (status_q == IbiSuccess) begin
      fail_status = (state_q == ReadAck) ? IbiFailureNack : IbiFailurePartialData;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      status_q <= IbiSuccess;
    end else if ((state_q == SendData || state_q == SendTbit) && stop) begin
      status_q <= fail_status;
    end else if (state_q == SendTbit && tx_done_i && q_byte_i.last) begin
      status_q <= IbiSuccess;
    end else if (state_q == ReadAck && !stop && rx_done_i && nack) begin
      status_q <= fail_status;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      retry_cnt_q <= 3'd7;
    end else if (state_q == Done) begin
      retry_cnt_q <= (status_q == IbiFailureNack) ? retry_cnt_q + 3'd1 : 3'd7;
    end
  end

  assign sda_start_low_o = (state_q == DriveStart);
  assign done_o          = (state_q == Done);
  assign ibi_status_o    = status_q;
  assign ibi_status_we_o = (state_q == Done) || (state_q == WaitStopOrRstart && stop);

endmodule

`default_nettype wire

/* source/ibi_queue.sv */
// Holds IBI bytes written by software until the sequencer sends or flushes them
`default_nettype none

module ibi_queue (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   wr_en_i,
  input  i3c_ibi_pkg::ibi_byte_t wr_byte_i,
  input  logic                   flush_i,
  input  logic                   rd_ready_i,
  output logic                   rd_valid_o,
  output i3c_ibi_pkg::ibi_byte_t rd_byte_o,
  output logic                   full_o
);
  import i3c_ibi_pkg::*;

  localparam int unsigned PtrW = $clog2(IbiQueueDepth);

  ibi_byte_t       mem_q [IbiQueueDepth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [PtrW:0]   count_q;
  logic            push;
  logic            pop;

  // Writes into a full queue are lost
  assign push = wr_en_i & ~full_o;
  assign pop  = rd_ready_i & rd_valid_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      // Abort empties the queue at once
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + (PtrW + 1)'(push) - (PtrW + 1)'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= wr_byte_i;
    end
  end

  assign rd_byte_o  = mem_q[rd_ptr_q];
  assign rd_valid_o = (count_q != '0);
  assign full_o     = (count_q == (PtrW + 1)'(IbiQueueDepth));

endmodule

`default_nettype wire

/* source/bus_rx.sv */
// Receives a requested bit or byte from SDA on SCL rising edges for the IBI sequencer
`default_nettype none

module bus_rx (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  i3c_ibi_pkg::bus_event_t bus_event_i,
  input  logic                    sda_i,
  input  logic                    req_byte_i,
  input  logic                    req_bit_i,
  output logic [7:0]              value_o,
  output logic                    done_o
);

  logic [7:0] shift_q;
  logic [3:0] bits_left_q;
  logic       busy_q;
  logic       done_q;
  logic       load;
  logic       sample;

  // No reload while the requester still sees done
  assign load   = ~busy_q & ~done_q & (req_byte_i | req_bit_i);
  assign sample = busy_q & bus_event_i.scl_posedge;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      bits_left_q <= '0;
      done_q      <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (load) begin
        busy_q      <= 1'b1;
        bits_left_q <= req_byte_i ? 4'd8 : 4'd1;
      end else if (sample) begin
        bits_left_q <= bits_left_q - 4'd1;
        if (bits_left_q == 4'd1) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  // Value stays put until the next request clears it
  always_ff @(posedge clk_i) begin
    if (load) begin
      shift_q <= '0;
    end else if (sample) begin
      shift_q <= {shift_q[6:0], sda_i};
    end
  end

  assign value_o = shift_q;
  assign done_o  = done_q;

endmodule

`default_nettype wire

/* source/bus_tx.sv */
// Serializes a requested byte or single bit onto SDA during SCL low phases for the IBI sequencer
`default_nettype none

module bus_tx (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  i3c_ibi_pkg::bus_event_t bus_event_i,
  input  logic                    req_byte_i,
  input  logic                    req_bit_i,
  input  logic [7:0]              value_i,
  input  logic                    push_pull_i,
  output logic                    sda_low_o,
  output logic                    done_o
);

  logic [7:0] shift_q;
  logic [3:0] bits_left_q;
  logic       busy_q;
  logic       pp_q;
  logic       od_low_q;
  logic       bit_low;
  logic       load;
  logic       shift;

  assign load  = ~busy_q & (req_byte_i | req_bit_i);
  assign shift = busy_q & bus_event_i.scl_negedge;

  // Done on the falling edge that closes the last bit
  assign done_o = shift & (bits_left_q == 4'd1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      bits_left_q <= '0;
      pp_q        <= 1'b0;
    end else if (load) begin
      busy_q      <= 1'b1;
      bits_left_q <= req_byte_i ? 4'd8 : 4'd1;
      pp_q        <= push_pull_i;
    end else if (shift) begin
      bits_left_q <= bits_left_q - 4'd1;
      if (bits_left_q == 4'd1) begin
        busy_q <= 1'b0;
      end
    end
  end

  // MSB first, a single bit goes out from bit 0
  always_ff @(posedge clk_i) begin
    if (load) begin
      shift_q <= req_byte_i ? value_i : {value_i[0], 7'b0};
    end else if (shift) begin
      shift_q <= {shift_q[6:0], 1'b0};
    end
  end

  assign bit_low = busy_q & ~shift_q[7];

  // Open-drain bits change one cycle later than push-pull bits
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      od_low_q <= 1'b0;
    end else begin
      od_low_q <= bit_low;
    end
  end

  assign sda_low_o = pp_q ? bit_low : od_low_q;

endmodule

`default_nettype wire

/* source/bus_monitor.sv */
// Samples SCL and SDA and reports edges, START, repeated START, STOP and bus idle to the IBI path
`default_nettype none

module bus_monitor (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    scl_i,
  input  logic                    sda_i,
  output i3c_ibi_pkg::bus_event_t bus_event_o
);
  import i3c_ibi_pkg::*;

  localparam int unsigned IdleCntW = $clog2(BusIdleCycles);

  logic [1:0]          scl_sync_q;
  logic [1:0]          sda_sync_q;
  logic                scl_prev_q;
  logic                sda_prev_q;
  logic [IdleCntW-1:0] idle_cnt_q;
  logic                bus_avail_q;
  logic                start_det;
  logic                stop_det;

  // Pins idle high, so the synchronizers reset high
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_sync_q <= 2'b11;
      sda_sync_q <= 2'b11;
      scl_prev_q <= 1'b1;
      sda_prev_q <= 1'b1;
    end else begin
      scl_sync_q <= {scl_sync_q[0], scl_i};
      sda_sync_q <= {sda_sync_q[0], sda_i};
      scl_prev_q <= scl_sync_q[1];
      sda_prev_q <= sda_sync_q[1];
    end
  end

  // SDA moving while SCL stays high
  assign start_det = scl_prev_q & scl_sync_q[1] & sda_prev_q & ~sda_sync_q[1];
  assign stop_det  = scl_prev_q & scl_sync_q[1] & ~sda_prev_q & sda_sync_q[1];

  // Any low pin restarts the idle count, so a START also clears availability
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idle_cnt_q  <= '0;
      bus_avail_q <= 1'b0;
    end else if (!(scl_sync_q[1] && sda_sync_q[1])) begin
      idle_cnt_q  <= '0;
      bus_avail_q <= 1'b0;
    end else if (idle_cnt_q == IdleCntW'(BusIdleCycles - 1)) begin
      bus_avail_q <= 1'b1;
    end else begin
      idle_cnt_q <= idle_cnt_q + 1'b1;
    end
  end

  assign bus_event_o.scl_negedge   = scl_prev_q & ~scl_sync_q[1];
  assign bus_event_o.scl_posedge   = ~scl_prev_q & scl_sync_q[1];
  assign bus_event_o.bus_available = bus_avail_q;
  assign bus_event_o.stop          = stop_det;
  // A START on a busy bus is a repeated START
  assign bus_event_o.rstart        = start_det & ~bus_avail_q;

endmodule

`default_nettype wire

/* source/i3c_ibi_pkg.sv */
// Shared types and sizes for the I3C target IBI path, imported by every RTL block and the testbench
`default_nettype none

package i3c_ibi_pkg;

  // Sizing
  localparam int unsigned IbiQueueDepth = 8;
  localparam int unsigned THdDatWidth   = 20;
  localparam int unsigned BusIdleCycles = 16;

  // Retry limit value that disables the limit
  localparam logic [2:0] RetryUnlimited = 3'd7;

  // Last IBI status as seen by software
  typedef enum logic [1:0] {
    IbiSuccess            = 2'b00,
    IbiFailureNack        = 2'b01,
    IbiFailurePartialData = 2'b10,
    IbiFailureRetry       = 2'b11
  } ibi_status_e;

  // One queued byte, last marks the end of the IBI payload
  typedef struct packed {
    logic       last;
    logic [7:0] data;
  } ibi_byte_t;

  // Bus monitor outputs, all one-cycle pulses except bus_available
  typedef struct packed {
    logic scl_negedge;
    logic scl_posedge;
    logic bus_available;
    logic stop;
    logic rstart;
  } bus_event_t;

endpackage

`default_nettype wire
